/* common/pong_pkg.sv */
package pong_pkg;

    // ========================================================================
    // Link message between the two boards
    // ========================================================================
    typedef enum logic [1:0] {
        MSG_BALL = 2'd1,
        MSG_LOSE = 2'd2
    } msg_kind_t;

    typedef struct packed {
        msg_kind_t         kind;
        logic [9:0]        y;
        logic signed [7:0] vy;
        logic [1:0]        gravity_phase;
        logic              fast;
        logic              spare;           // Always sent as zero.
    } link_msg_t;

    localparam int MSG_BITS = $bits(link_msg_t);

    // ========================================================================
    // Ball state and screen geometry
    // ========================================================================
    typedef struct packed {
        logic [9:0]        x;
        logic [9:0]        y;
        logic signed [9:0] vy;
        logic [1:0]        gravity_phase;
    } ball_t;

    localparam logic [9:0]        X_STEP    = 10'd8;     // Pixels per step.
    localparam logic [9:0]        X_SERVE   = 10'd20;
    localparam logic [9:0]        X_RESET   = 10'd10;
    localparam logic [9:0]        Y_RESET   = 10'd80;
    localparam logic signed [9:0] VY_SERVE  = -10'sd3;
    localparam logic [9:0]        X_EDGE_LO = 10'd320;
    localparam logic [9:0]        X_EDGE_HI = 10'd640;
    localparam logic [9:0]        Y_MAX_LO  = 10'd239;
    localparam logic [9:0]        Y_MAX_HI  = 10'd479;

endpackage

/* game/ball_stepper.sv */
module ball_stepper #(
    parameter int TICK_BASE = 270000
) (
    input  logic            clk_25MHZ,
    input  logic            reset,
    input  logic            upscale,
    input  logic            load,
    input  pong_pkg::ball_t load_ball,
    input  logic            fast,
    input  logic            run,
    input  logic            direction_right,
    input  logic            collide,
    input  logic [9:0]      estimated_speed,
    output pong_pkg::ball_t ball
);
    import pong_pkg::*;

    logic [31:0]        count;
    logic [31:0]        period;
    logic               step;
    logic [9:0]         y_max;
    logic [9:0]         safe_speed;
    logic signed [9:0]  vy_grav;
    logic signed [11:0] y_sum;
    ball_t              step_ball;

    assign y_max      = upscale ? Y_MAX_HI : Y_MAX_LO;
    assign safe_speed = (estimated_speed < 10'd2) ? 10'd1 : estimated_speed;
    assign step       = run && (count + 32'd1 >= period);

    // ========================================================================
    // Next ball state for one step
    // ========================================================================
    always_comb begin
        vy_grav = ball.vy;
        if (ball.gravity_phase == 2'd3) begin
            vy_grav = ball.vy + 10'sd1;                 // Gravity acts every fourth step.
        end
        y_sum = $signed({2'b00, ball.y}) + $signed({{2{ball.vy[9]}}, ball.vy});

        step_ball.gravity_phase = ball.gravity_phase + 2'd1;
        if (direction_right) begin
            step_ball.x = ball.x + X_STEP;
        end else begin
            step_ball.x = (ball.x >= X_STEP) ? ball.x - X_STEP : '0;
        end

        if (y_sum <= 12'sd0) begin
            step_ball.y  = '0;
            step_ball.vy = -vy_grav;                     // Bounce off the top row.
        end else if (y_sum >= $signed({2'b00, y_max})) begin
            step_ball.y  = y_max;
            step_ball.vy = vy_grav;
        end else begin
            step_ball.y  = y_sum[9:0];
            step_ball.vy = vy_grav;
        end
    end

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            ball   <= '{x: X_RESET, y: Y_RESET, vy: VY_SERVE, gravity_phase: 2'd0};
            count  <= '0;
            period <= 32'(TICK_BASE);
        end else if (load) begin
            ball   <= load_ball;
            count  <= '0;
            period <= fast ? 32'(TICK_BASE) : 32'(TICK_BASE / 2);
        end else if (collide) begin
            count  <= '0;
            period <= 32'(TICK_BASE) / {22'd0, safe_speed};  // Harder swing, shorter period.
        end else if (step) begin
            ball  <= step_ball;
            count <= '0;
        end else if (run) begin
            count <= count + 32'd1;
        end
    end

    assert property (@(posedge clk_25MHZ) disable iff (reset) ball.y <= y_max)
        else $error("ball row beyond the last screen row");

endmodule

/* game/game_controller.sv */
module game_controller (
    input  logic                clk_25MHZ,
    input  logic                reset,
    input  logic                upscale,
    input  logic                game_start,
    input  logic                collision_detected,
    input  logic [9:0]          estimated_speed,
    input  pong_pkg::ball_t     ball,
    input  pong_pkg::link_msg_t rx_msg,
    input  logic                rx_ready,
    input  logic                tx_done,
    output logic                load,
    output pong_pkg::ball_t     load_ball,
    output logic                run,
    output logic                direction_right,
    output logic                collide,
    output logic                fast_serve,
    output logic                tx_start,
    output pong_pkg::link_msg_t tx_msg,
    output logic                rx_ack,
    output logic                game_over,
    output logic [7:0]          score,
    output logic                is_you_win,
    output logic                is_lose,
    output logic                idle,
    output logic [7:0]          led
);
    import pong_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE, ST_ACK, ST_RUN_RIGHT, ST_RUN_LEFT,
        ST_SEND_BALL, ST_AWAIT, ST_SEND_LOSE, ST_STOP
    } state_t;

    state_t     state;
    logic       resume;        // The acknowledged message carried a ball.
    logic       hit_fast;
    logic [9:0] x_miss;

    assign run             = (state == ST_RUN_RIGHT) || (state == ST_RUN_LEFT);
    assign direction_right = (state == ST_RUN_RIGHT);
    assign idle            = (state == ST_IDLE);
    assign led             = 8'd1 << state;                         // One bit per state.
    assign x_miss          = (upscale ? X_EDGE_HI : X_EDGE_LO) - 10'd20;

    // ========================================================================
    // Serve, rally and handover sequence
    // ========================================================================
    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            state      <= ST_IDLE;
            load       <= 1'b0;
            load_ball  <= '0;
            collide    <= 1'b0;
            fast_serve <= 1'b0;
            tx_start   <= 1'b0;
            tx_msg     <= '0;
            rx_ack     <= 1'b0;
            game_over  <= 1'b0;
            score      <= '0;
            is_you_win <= 1'b0;
            is_lose    <= 1'b0;
            resume     <= 1'b0;
            hit_fast   <= 1'b0;
        end else begin
            load    <= 1'b0;
            collide <= 1'b0;
            rx_ack  <= 1'b0;
            case (state)
                ST_IDLE, ST_AWAIT: begin
                    if (state == ST_IDLE && game_start) begin
                        load       <= 1'b1;
                        load_ball  <= '{x: X_SERVE, y: Y_RESET, vy: VY_SERVE,
                                        gravity_phase: 2'd0};
                        fast_serve <= 1'b1;
                        score      <= '0;
                        is_you_win <= 1'b0;
                        state      <= ST_RUN_RIGHT;
                    end else if (rx_ready) begin
                        rx_ack <= 1'b1;                             // Single cycle pulse.
                        resume <= (rx_msg.kind == MSG_BALL);
                        state  <= ST_ACK;
                        if (rx_msg.kind == MSG_BALL) begin
                            load       <= 1'b1;
                            load_ball  <= '{x: X_SERVE, y: rx_msg.y,
                                            vy: {{2{rx_msg.vy[7]}}, rx_msg.vy},
                                            gravity_phase: rx_msg.gravity_phase};
                            fast_serve <= rx_msg.fast;
                            is_you_win <= 1'b0;
                        end else if (state == ST_AWAIT) begin
                            is_you_win <= 1'b1;                     // Peer missed our ball.
                        end
                    end
                end

                ST_ACK: begin
                    state <= resume ? ST_RUN_RIGHT : ST_IDLE;
                end

                ST_RUN_RIGHT: begin
                    if (collision_detected) begin
                        collide  <= 1'b1;
                        hit_fast <= (estimated_speed >= 10'd2);
                        state    <= ST_RUN_LEFT;
                    end else if (ball.x >= x_miss) begin
                        tx_msg    <= '{kind: MSG_LOSE, y: '0, vy: '0, gravity_phase: '0,
                                       fast: 1'b0, spare: 1'b0};
                        tx_start  <= 1'b1;
                        game_over <= 1'b1;
                        is_lose   <= 1'b1;
                        state     <= ST_SEND_LOSE;
                    end
                end

                ST_RUN_LEFT: begin
                    if (ball.x == '0) begin
                        score    <= score + 8'd1;
                        tx_msg   <= '{kind: MSG_BALL, y: ball.y, vy: ball.vy[7:0],
                                      gravity_phase: ball.gravity_phase,
                                      fast: hit_fast, spare: 1'b0};
                        tx_start <= 1'b1;
                        state    <= ST_SEND_BALL;
                    end
                end

                ST_SEND_BALL: begin
                    if (tx_done) begin
                        tx_start <= 1'b0;
                        state    <= ST_AWAIT;
                    end
                end

                ST_SEND_LOSE: begin
                    if (tx_done) begin
                        tx_start <= 1'b0;
                        is_lose  <= 1'b0;
                        state    <= ST_STOP;
                    end
                end

                ST_STOP: begin
                    if (!tx_done) begin                             // Link has seen the drop.
                        game_over <= 1'b0;
                        state     <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // The ball is frozen for the whole of a send.
    assert property (@(posedge clk_25MHZ) disable iff (reset) !(tx_start && run))
        else $error("tx_start high while the ball is running");

    assert property (@(posedge clk_25MHZ) disable iff (reset) rx_ack |-> rx_ready)
        else $error("rx_ack without a held message");

endmodule

/* link/link_tx.sv */
module link_tx (
    input  logic                clk_25MHZ,
    input  logic                reset,
    input  logic                tx_start,
    input  pong_pkg::link_msg_t tx_msg,
    output logic                tx_done,
    output logic                link_out_bit,
    output logic                link_out_valid
);
    import pong_pkg::*;

    localparam int               CNT_W    = $clog2(MSG_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(MSG_BITS - 1);

    logic [MSG_BITS-1:0] shift_reg;
    logic [CNT_W-1:0]    bit_cnt;
    logic                start_d;
    logic                start_edge;

    assign start_edge   = tx_start && !start_d && !link_out_valid && !tx_done;
    assign link_out_bit = shift_reg[0] & link_out_valid;          // LSB goes out first.

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            start_d        <= 1'b0;
            bit_cnt        <= '0;
            link_out_valid <= 1'b0;
            tx_done        <= 1'b0;
        end else begin
            start_d <= tx_start;
            if (link_out_valid) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == LAST_BIT) begin
                    link_out_valid <= 1'b0;
                    tx_done        <= 1'b1;
                end
            end else if (start_edge) begin
                link_out_valid <= 1'b1;
                bit_cnt        <= '0;
            end else if (tx_done && !tx_start) begin
                tx_done <= 1'b0;                                // Level done, cleared by the sender.
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (start_edge) begin
            shift_reg <= tx_msg;
        end else if (link_out_valid) begin
            shift_reg <= shift_reg >> 1;
        end
    end

    assert property (@(posedge clk_25MHZ) disable iff (reset) tx_done |-> !link_out_valid)
        else $error("frame on the wire while tx_done is high");

endmodule

/* link/link_rx.sv */
module link_rx (
    input  logic                clk_25MHZ,
    input  logic                reset,
    input  logic                link_in_bit,
    input  logic                link_in_valid,
    input  logic                rx_ack,
    output pong_pkg::link_msg_t rx_msg,
    output logic                rx_ready
);
    import pong_pkg::*;

    localparam int               CNT_W    = $clog2(MSG_BITS);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(MSG_BITS - 1);

    logic [MSG_BITS-1:0] shift_reg;
    logic [MSG_BITS-1:0] frame;
    logic [CNT_W-1:0]    bit_cnt;
    logic                frame_done;

    // New bits enter at the top so the first bit lands in bit 0.
    assign frame      = {link_in_bit, shift_reg[MSG_BITS-1:1]};
    assign frame_done = link_in_valid && (bit_cnt == LAST_BIT);

    always_ff @(posedge clk_25MHZ or posedge reset) begin
        if (reset) begin
            bit_cnt  <= '0;
            rx_ready <= 1'b0;
        end else begin
            if (link_in_valid) begin
                bit_cnt <= frame_done ? '0 : bit_cnt + 1'b1;
            end else begin
                bit_cnt <= '0;                                  // Idle line realigns the frame.
            end
            if (rx_ack) begin
                rx_ready <= 1'b0;
            end else if (frame_done) begin
                rx_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_25MHZ) begin
        if (link_in_valid) begin
            shift_reg <= frame;
        end
        if (frame_done && !rx_ready) begin
            rx_msg <= frame;                                    // A held message is never overwritten.
        end
    end

endmodule

/* hdl/pong_board.sv */
module pong_board #(
    parameter int TICK_BASE = 270000
) (
    input  logic       clk_25MHZ,
    input  logic       reset,
    input  logic       upscale,
    input  logic       game_start,
    input  logic       collision_detected,
    input  logic [9:0] estimated_speed,
    input  logic       link_in_bit,
    input  logic       link_in_valid,
    output logic [9:0] ball_x,
    output logic [9:0] ball_y,
    output logic       moving_right,
    output logic       game_over,
    output logic [7:0] score,
    output logic       is_you_win,
    output logic       is_lose,
    output logic       idle,
    output logic [7:0] led,
    output logic       link_out_bit,
    output logic       link_out_valid
);
    import pong_pkg::*;

    ball_t     ball;
    ball_t     load_ball;
    link_msg_t tx_msg;
    link_msg_t rx_msg;
    logic      load, run, direction_right, collide, fast_serve;
    logic      tx_start, tx_done, rx_ready, rx_ack;

    assign ball_x       = ball.x;
    assign ball_y       = ball.y;
    assign moving_right = direction_right;

    game_controller u_game_controller (.*);

    ball_stepper #(
        .TICK_BASE(TICK_BASE)
    ) u_ball_stepper (
        .fast(fast_serve),
        .*
    );

    link_tx u_link_tx (.*);

    link_rx u_link_rx (.*);

endmodule

/* verification/peer_board_model.sv */
module peer_board_model (
    input  logic clk_25MHZ,
    input  logic link_out_bit,
    input  logic link_out_valid,
    output logic link_in_bit,
    output logic link_in_valid
);
    timeunit 1ns;
    timeprecision 1ps;

    import pong_pkg::*;

    link_msg_t           last_msg;
    int                  frame_count;
    logic [MSG_BITS-1:0] bits;
    int                  bit_index;

    initial begin
        link_in_bit   = 1'b0;
        link_in_valid = 1'b0;
        last_msg      = '0;
        frame_count   = 0;
        bit_index     = 0;
    end

    // Bits from the DUT are taken at the falling edge, in the middle of each bit.
    always @(negedge clk_25MHZ) begin
        if (link_out_valid === 1'b1) begin
            bits[bit_index] = link_out_bit;             // First bit on the wire is bit 0.
            bit_index = bit_index + 1;
            if (bit_index == MSG_BITS) begin
                last_msg    = link_msg_t'(bits);
                frame_count = frame_count + 1;
                bit_index   = 0;
            end
        end else begin
            bit_index = 0;
        end
    end

    task automatic send_frame(input link_msg_t msg);
        logic [MSG_BITS-1:0] word;
        word = msg;
        for (int i = 0; i < MSG_BITS; i++) begin
            @(posedge clk_25MHZ);
            #2;
            link_in_bit   = word[i];
            link_in_valid = 1'b1;
        end
        @(posedge clk_25MHZ);
        #2;
        link_in_bit   = 1'b0;
        link_in_valid = 1'b0;
    endtask

endmodule

/* verification/pong_board_tb.sv */
module pong_board_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import pong_pkg::*;

    localparam int TICK_BASE  = 8;
    localparam int CLK_PERIOD = 40;
    localparam int STEP_LIMIT = 2 * TICK_BASE + 4;
    localparam int FRAME_WAIT = 2 * MSG_BITS;
    localparam int STEPS_LO   = (X_EDGE_LO - 10'd20 - X_SERVE) / X_STEP;
    localparam int STEPS_HI   = (X_EDGE_HI - 10'd20 - X_SERVE) / X_STEP;
    // A full crossing at each width, plus every frame and some slack.
    localparam int RUN_CYCLES = STEPS_LO * TICK_BASE + STEPS_HI * (TICK_BASE / 2)
                                + 8 * (MSG_BITS + 8) + 200;

    logic       clk_25MHZ;
    logic       reset;
    logic       upscale;
    logic       game_start;
    logic       collision_detected;
    logic [9:0] estimated_speed;
    logic       link_in_bit;
    logic       link_in_valid;
    logic [9:0] ball_x;
    logic [9:0] ball_y;
    logic       moving_right;
    logic       game_over;
    logic [7:0] score;
    logic       is_you_win;
    logic       is_lose;
    logic       idle;
    logic [7:0] led;
    logic       link_out_bit;
    logic       link_out_valid;

    int errors;
    int tests_run;
    int tests_failed;
    int seed;
    int frames_seen;
    int mx;
    int my;
    int mvy;
    int mph;

    pong_board #(
        .TICK_BASE(TICK_BASE)
    ) uut (.*);

    peer_board_model peer (.*);

    initial begin
        clk_25MHZ = 1'b0;
        forever #(CLK_PERIOD / 2) clk_25MHZ = ~clk_25MHZ;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", RUN_CYCLES);
        $display("sim failed");
        $finish;
    end

    // ========================================================================
    // Helpers
    // ========================================================================
    task automatic tick();
        @(posedge clk_25MHZ);
        #2;
    endtask

    task automatic check_value(input string name, input int expected, input int actual);
        assert (expected == actual) else begin
            $display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
            errors++;
        end
    endtask

    function automatic bit flag_value(input string name);
        if (name == "moving_right") return moving_right;
        if (name == "game_over") return game_over;
        if (name == "is_you_win") return is_you_win;
        if (name == "idle") return idle;
        if (name == "new_frame") return peer.frame_count != frames_seen;
        return 1'b0;
    endfunction

    task automatic wait_flag(input string name, input int limit);
        int waited;
        waited = 0;
        while (!flag_value(name) && waited < limit) begin
            tick();
            waited++;
        end
        assert (flag_value(name)) else begin
            $display("timeout at %0t ns: %s did not come within %0d cycles", $time, name, limit);
            errors++;
        end
    endtask

    // Reference ball motion for one step.
    task automatic advance_model(input bit right);
        int y_sum;
        int vy_next;
        int y_lim;
        y_lim   = upscale ? Y_MAX_HI : Y_MAX_LO;
        y_sum   = my + mvy;
        vy_next = (mph == 3) ? mvy + 1 : mvy;
        mph     = (mph + 1) % 4;
        if (right) begin
            mx = mx + X_STEP;
        end else begin
            mx = (mx >= X_STEP) ? mx - X_STEP : 0;
        end
        if (y_sum <= 0) begin
            my  = 0;
            mvy = -vy_next;
        end else if (y_sum >= y_lim) begin
            my  = y_lim;
            mvy = vy_next;
        end else begin
            my  = y_sum;
            mvy = vy_next;
        end
    endtask

    task automatic expect_step(input bit right, output bit ok, output int gap);
        int         waited;
        logic [9:0] old_x;
        waited = 0;
        old_x  = ball_x;
        while (ball_x == old_x && waited < STEP_LIMIT) begin
            tick();
            waited++;
        end
        gap = waited;
        ok  = (ball_x != old_x);
        assert (ok) else begin
            $display("timeout at %0t ns: ball stayed at column %0d", $time, old_x);
            errors++;
        end
        advance_model(right);
        check_value("ball_x", mx, ball_x);
        check_value("ball_y", my, ball_y);
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_before);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic reset_values();
        check_value("ball_x", X_RESET, ball_x);
        check_value("ball_y", Y_RESET, ball_y);
        check_value("idle", 1, idle);
        check_value("led[0]", 1, led[0]);
        check_value("score", 0, score);
        check_value("game_over", 0, game_over);
        check_value("moving_right", 0, moving_right);
    endtask

    task automatic serve_and_miss();
        bit ok;
        int gap;
        int waited;
        frames_seen = peer.frame_count;
        upscale     = 1'b0;
        game_start  = 1'b1;
        tick();
        game_start = 1'b0;
        waited = 0;
        while (ball_x != X_SERVE && waited < 8) begin
            tick();
            waited++;
        end
        mx  = X_SERVE;
        my  = Y_RESET;
        mvy = VY_SERVE;
        mph = 0;
        check_value("ball_x", mx, ball_x);
        check_value("moving_right", 1, moving_right);
        ok = 1'b1;
        while (mx < X_EDGE_LO - 20 && ok) begin
            expect_step(1'b1, ok, gap);
        end
        wait_flag("game_over", 4);
        check_value("is_lose", 1, is_lose);
        wait_flag("new_frame", FRAME_WAIT);
        check_value("frame kind", MSG_LOSE, peer.last_msg.kind);
        wait_flag("idle", 8);
        check_value("frame count", frames_seen + 1, peer.frame_count);
        check_value("game_over", 0, game_over);
        check_value("is_lose", 0, is_lose);
    endtask

    task automatic receive_ball();
        link_msg_t msg;
        int        vy_pick;
        vy_pick           = $random(seed) % 4;
        msg               = '0;
        msg.kind          = MSG_BALL;
        msg.y             = 10'd40 + 10'($random(seed) & 127);
        msg.vy            = 8'(vy_pick);
        msg.gravity_phase = 2'($random(seed));
        peer.send_frame(msg);
        wait_flag("moving_right", 8);
        check_value("ball_x", X_SERVE, ball_x);
        check_value("ball_y", msg.y, ball_y);
        mx  = X_SERVE;
        my  = msg.y;
        mvy = vy_pick;
        mph = msg.gravity_phase;
    endtask

    task automatic return_and_handover();
        bit ok;
        int gap;
        int n;
        int score_before;
        score_before       = score;
        frames_seen        = peer.frame_count;
        estimated_speed    = 10'd4;
        collision_detected = 1'b1;
        tick();
        collision_detected = 1'b0;
        check_value("moving_right", 0, moving_right);
        check_value("ball_x", X_SERVE, ball_x);
        n  = 0;
        ok = 1'b1;
        while (mx > 0 && ok) begin
            expect_step(1'b0, ok, gap);
            if (n > 0) begin
                check_value("step gap", TICK_BASE / 4, gap);
            end
            n++;
        end
        wait_flag("new_frame", FRAME_WAIT);
        check_value("score", score_before + 1, score);
        check_value("frame kind", MSG_BALL, peer.last_msg.kind);
        check_value("frame y", my, peer.last_msg.y);
        check_value("frame vy", mvy, $signed(peer.last_msg.vy));
        check_value("frame gravity_phase", mph, peer.last_msg.gravity_phase);
    endtask

    task automatic win_after_handover();
        link_msg_t msg;
        msg      = '0;
        msg.kind = MSG_LOSE;
        peer.send_frame(msg);
        wait_flag("is_you_win", 8);
        wait_flag("idle", 8);
        check_value("is_you_win", 1, is_you_win);
    endtask

    task automatic vertical_bounds();
        link_msg_t msg;
        bit        ok;
        int        gap;
        int        last_y;
        bit        saw_top;
        bit        saw_bottom;
        upscale  = 1'b1;
        msg      = '0;
        msg.kind = MSG_BALL;
        msg.y    = 10'd5;
        msg.vy   = -8'sd4;
        peer.send_frame(msg);
        wait_flag("moving_right", 8);
        mx         = X_SERVE;
        my         = 5;
        mvy        = -4;
        mph        = 0;
        last_y     = ball_y;
        saw_top    = 1'b0;
        saw_bottom = 1'b0;
        ok         = 1'b1;
        while (mx < X_EDGE_HI - 20 && ok) begin
            expect_step(1'b1, ok, gap);
            if (last_y == 0) begin
                assert (ball_y > 0) else begin
                    $display("error at %0t ns: ball did not leave row 0 after the bounce", $time);
                    errors++;
                end
            end
            saw_top    = saw_top || (ball_y == 0);
            saw_bottom = saw_bottom || (ball_y == Y_MAX_HI);
            last_y     = ball_y;
        end
        check_value("row 0 reached", 1, saw_top);
        check_value("row 479 reached", 1, saw_bottom);
        wait_flag("game_over", 4);
        wait_flag("idle", FRAME_WAIT);
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================
    initial begin
        int start_errors;
        errors             = 0;
        tests_run          = 0;
        tests_failed       = 0;
        frames_seen        = 0;
        seed               = 32'hced0;
        reset              = 1'b1;
        upscale            = 1'b0;
        game_start         = 1'b0;
        collision_detected = 1'b0;
        estimated_speed    = 10'd0;
        repeat (8) @(posedge clk_25MHZ);
        #2;
        reset = 1'b0;

        start_errors = errors;
        reset_values();
        finish_test("reset values", start_errors);
        start_errors = errors;
        serve_and_miss();
        finish_test("serve and miss", start_errors);
        start_errors = errors;
        receive_ball();
        finish_test("received ball", start_errors);
        start_errors = errors;
        return_and_handover();
        finish_test("return and handover", start_errors);
        start_errors = errors;
        win_after_handover();
        finish_test("win", start_errors);
        start_errors = errors;
        vertical_bounds();
        finish_test("vertical bounds", start_errors);

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* pong_board.f */
common/pong_pkg.sv
game/ball_stepper.sv
game/game_controller.sv
link/link_tx.sv
link/link_rx.sv
hdl/pong_board.sv
verification/peer_board_model.sv
verification/pong_board_tb.sv

/* Bender.yml */
package:
  name: pong_board

sources:
  - common/pong_pkg.sv
  - game/ball_stepper.sv
  - game/game_controller.sv
  - link/link_tx.sv
  - link/link_rx.sv
  - hdl/pong_board.sv
  - target: simulation
    files:
      - verification/peer_board_model.sv
      - verification/pong_board_tb.sv
